/* stream_buffer_top.f */
+incdir+verilog
verilog/stream_buffer_pkg.sv
verilog/byte_packer.sv
verilog/sync_fifo.sv
verilog/word_checksum.sv
verilog/stream_buffer_top.sv
testbench/stream_buffer_tb.sv

/* testbench/stream_buffer_tb.sv */
`timescale 1ns/1ps

`include "stream_buffer_defines.svh"

// testbench for the byte stream capture buffer
// a cycle model of packer, fifo and checksum runs beside the DUT
// and every output is compared with it on each falling edge

module stream_buffer_tb;

   localparam int STIM_CYCLES    = 700;                // upper bound over all tests
   localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;
   localparam int DEPTH          = `FIFO_DEPTH;

   logic                      i_clk;
   logic                      i_rst;
   stream_buffer_pkg::byte_t  i_byte;
   logic                      i_byte_stb;
   logic                      i_pop;
   logic                      o_empty;
   logic                      o_full;
   logic                      o_overrun;
   logic                      o_underrun;
   stream_buffer_pkg::word_t  o_sum;
   stream_buffer_pkg::count_t o_count;

   // model state
   stream_buffer_pkg::byte_t  bq[$];       // bytes of the word being packed
   stream_buffer_pkg::word_t  wq[$];       // words held in the fifo
   stream_buffer_pkg::word_t  m_wr_word;   // packer output register
   logic                      m_wr_pend;   // mirrors pk_write
   stream_buffer_pkg::word_t  m_dlv_word;  // fifo read register
   logic                      m_dlv_valid; // mirrors ff_rd_valid
   stream_buffer_pkg::word_t  m_sum;
   stream_buffer_pkg::count_t m_count;
   logic                      m_empty;
   logic                      m_full;
   logic                      m_overrun;
   logic                      m_underrun;
   logic                      model_ready = 1'b0; // set once the model has seen reset

   string                     test_name = "reset";
   int                        cycle_count = 0;

   stream_buffer_top dut0 (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_byte     (i_byte),
      .i_byte_stb (i_byte_stb),
      .i_pop      (i_pop),
      .o_empty    (o_empty),
      .o_full     (o_full),
      .o_overrun  (o_overrun),
      .o_underrun (o_underrun),
      .o_sum      (o_sum),
      .o_count    (o_count)
   );

   initial i_clk = 1'b0;
   always #20 i_clk = ~i_clk; // 40 ns period

   // expected {count, sum} after one more delivered word
   function automatic logic [`COUNT_BITS+31:0] expect_checksum(
      input stream_buffer_pkg::word_t  sum,
      input stream_buffer_pkg::count_t count,
      input stream_buffer_pkg::word_t  word);
      logic [`COUNT_BITS+31:0] r;
      r[31:0]            = sum + word;                       // mod 2^32
      r[`COUNT_BITS+31:32] = count + stream_buffer_pkg::count_t'(1); // wraps
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
         $display("Verification failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   // cycle model, sees the inputs exactly as the DUT samples them
   always @(posedge i_clk) begin : model_step
      logic                     was_empty;
      logic                     honour;
      logic                     accept;
      logic                     wr_pend_n;
      logic [`COUNT_BITS+31:0]  ck;
      if (i_rst) begin
         bq.delete();
         wq.delete();
         m_wr_pend   = 1'b0;
         m_dlv_valid = 1'b0;
         m_sum       = '0;
         m_count     = '0;
         m_empty     = 1'b1;
         m_full      = 1'b0;
         m_overrun   = 1'b0;
         m_underrun  = 1'b0;
         model_ready = 1'b1;
      end else begin
         if (m_dlv_valid) begin // checksum stage, one cycle behind the pop
            ck      = expect_checksum(m_sum, m_count, m_dlv_word);
            m_sum   = ck[31:0];
            m_count = ck[`COUNT_BITS+31:32];
         end
         was_empty = (wq.size() == 0);
         honour    = i_pop && !was_empty;
         accept    = m_wr_pend && ((wq.size() < DEPTH) || honour);
         if (m_wr_pend && !accept) m_overrun = 1'b1; // word dropped
         if (i_pop && was_empty) m_underrun = 1'b1;
         m_dlv_valid = honour;
         if (honour) m_dlv_word = wq.pop_front(); // old head leaves before the new word
         if (accept) wq.push_back(m_wr_word);
         m_empty = (wq.size() == 0);
         m_full  = (wq.size() == DEPTH);
         wr_pend_n = 1'b0;
         if (i_byte_stb) begin
            bq.push_back(i_byte);
            if (bq.size() == 4) begin
               m_wr_word = {bq[3], bq[2], bq[1], bq[0]}; // first byte in bits 7..0
               bq.delete();
               wr_pend_n = 1'b1;
            end
         end
         m_wr_pend = wr_pend_n;
      end
   end

   // compare every output against the model mid cycle
   always @(negedge i_clk) begin
      if (model_ready) begin
         check({test_name, " o_empty"}, m_empty, o_empty);
         check({test_name, " o_full"}, m_full, o_full);
         check({test_name, " o_overrun"}, m_overrun, o_overrun);
         check({test_name, " o_underrun"}, m_underrun, o_underrun);
         check({test_name, " o_sum"}, m_sum, o_sum);
         check({test_name, " o_count"}, m_count, o_count);
      end
   end

   // stuck run guard
   always @(posedge i_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Run did not finish within %0d cycles, stuck in %s", TIMEOUT_CYCLES,
                  test_name);
         $display("Verification failed");
         $fatal(1, "timeout");
      end
   end

   task automatic apply_reset();
      @(posedge i_clk);
      i_rst      <= 1'b1;
      i_byte_stb <= 1'b0;
      i_pop      <= 1'b0;
      repeat (2) @(posedge i_clk);
      i_rst <= 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge i_clk);
         i_byte_stb <= 1'b0;
         i_pop      <= 1'b0;
      end
   endtask

   task automatic send_byte(input stream_buffer_pkg::byte_t b);
      @(posedge i_clk);
      i_byte     <= b;
      i_byte_stb <= 1'b1;
      i_pop      <= 1'b0;
   endtask

   task automatic send_word(input stream_buffer_pkg::word_t w);
      for (int k = 0; k < 4; k++) begin
         send_byte(w[8*k +: 8]); // back to back, lane 0 first
      end
   endtask

   task automatic pop_once();
      @(posedge i_clk);
      i_byte_stb <= 1'b0;
      i_pop      <= 1'b1;
   endtask

   task automatic drain(input int n);
      repeat (n) pop_once();
      idle(3); // pop -> valid -> sum
   endtask

   initial begin : stimulus
      stream_buffer_pkg::word_t  w;
      stream_buffer_pkg::byte_t  b;
      stream_buffer_pkg::word_t  exp_sum;
      stream_buffer_pkg::count_t exp_count;
      logic [`COUNT_BITS+31:0]   ck;
      i_rst      = 1'b0;
      i_byte     = '0;
      i_byte_stb = 1'b0;
      i_pop      = 1'b0;
      void'($urandom(40));
      apply_reset();

      test_name = "reset_state";
      @(negedge i_clk);
      check("reset_state o_empty", 1, o_empty);
      check("reset_state o_full", 0, o_full);
      check("reset_state o_overrun", 0, o_overrun);
      check("reset_state o_underrun", 0, o_underrun);
      check("reset_state o_sum", 0, o_sum);
      check("reset_state o_count", 0, o_count);

      test_name = "pack_checksum";
      exp_sum   = '0;
      exp_count = '0;
      for (int i = 0; i < 40; i++) begin
         b = stream_buffer_pkg::byte_t'($urandom);
         w[8*(i%4) +: 8] = b;
         send_byte(b);
         idle($urandom % 3); // random gap between strobes
         if (i % 4 == 3) begin
            ck        = expect_checksum(exp_sum, exp_count, w);
            exp_sum   = ck[31:0];
            exp_count = ck[`COUNT_BITS+31:32];
         end
      end
      idle(3);
      drain(10);
      @(negedge i_clk);
      check("pack_checksum sum", exp_sum, o_sum);
      check("pack_checksum count", exp_count, o_count);
      check("pack_checksum empty", 1, o_empty);

      test_name = "full_overrun";
      for (int i = 0; i < DEPTH; i++) begin
         w = $urandom;
         send_word(w);
         ck        = expect_checksum(exp_sum, exp_count, w);
         exp_sum   = ck[31:0];
         exp_count = ck[`COUNT_BITS+31:32];
      end
      idle(3);
      @(negedge i_clk);
      check("full_overrun full", 1, o_full);
      check("full_overrun overrun before", 0, o_overrun);
      send_word($urandom); // no room, this word is lost
      idle(3);
      @(negedge i_clk);
      check("full_overrun overrun after", 1, o_overrun);
      drain(DEPTH);
      @(negedge i_clk);
      check("full_overrun sum", exp_sum, o_sum);
      check("full_overrun count", exp_count, o_count);
      check("full_overrun empty", 1, o_empty);

      test_name = "underrun";
      pop_once();
      idle(3);
      @(negedge i_clk);
      check("underrun flag", 1, o_underrun);
      check("underrun sum", exp_sum, o_sum);
      check("underrun count", exp_count, o_count);

      test_name = "full_concurrent";
      apply_reset(); // clears the sticky flags
      exp_sum   = '0;
      exp_count = '0;
      for (int i = 0; i <= DEPTH; i++) begin
         w = $urandom;
         send_word(w);
         if (i == DEPTH - 1) begin
            idle(3);
            @(negedge i_clk);
            check("full_concurrent full", 1, o_full);
         end
         ck        = expect_checksum(exp_sum, exp_count, w);
         exp_sum   = ck[31:0];
         exp_count = ck[`COUNT_BITS+31:32];
      end
      pop_once(); // sampled on the same edge as the packer write
      idle(3);
      @(negedge i_clk);
      check("full_concurrent full after", 1, o_full);
      check("full_concurrent overrun", 0, o_overrun);
      drain(DEPTH);
      @(negedge i_clk);
      check("full_concurrent sum", exp_sum, o_sum);
      check("full_concurrent count", exp_count, o_count);

      test_name = "random_mix";
      repeat (300) begin
         @(posedge i_clk);
         i_byte     <= stream_buffer_pkg::byte_t'($urandom);
         i_byte_stb <= ($urandom % 2 == 0);
         i_pop      <= ($urandom % 6 == 0);
      end
      idle(4);
      drain(DEPTH + 4); // extra pops only add to underrun
      @(negedge i_clk);
      check("random_mix empty", 1, o_empty);

      $display("Verification passed");
      $finish;
   end

endmodule

/* verilog/stream_buffer_top.sv */
`timescale 1ns/1ps

// byte stream capture buffer
// bytes in -> packer -> fifo -> checksum
// fourth byte to o_empty low is 2 cycles
// honoured pop to updated o_sum is 2 cycles

module stream_buffer_top (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  stream_buffer_pkg::byte_t  i_byte,
   input  logic                      i_byte_stb,
   input  logic                      i_pop,      // request one word
   output logic                      o_empty,
   output logic                      o_full,
   output logic                      o_overrun,  // sticky
   output logic                      o_underrun, // sticky
   output stream_buffer_pkg::word_t  o_sum,
   output stream_buffer_pkg::count_t o_count
);

   // packer to fifo
   stream_buffer_pkg::word_t pk_word;
   logic                     pk_write;

   // fifo to checksum
   stream_buffer_pkg::word_t ff_rd_data;
   logic                     ff_rd_valid;

   byte_packer pk0 (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_byte     (i_byte),
      .i_byte_stb (i_byte_stb),
      .o_word     (pk_word),
      .o_write    (pk_write)
   );

   sync_fifo ff0 (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_wr_data  (pk_word),
      .i_write    (pk_write),    // no back-pressure to the packer
      .i_pop      (i_pop),
      .o_rd_data  (ff_rd_data),
      .o_rd_valid (ff_rd_valid),
      .o_empty    (o_empty),
      .o_full     (o_full),
      .o_overrun  (o_overrun),
      .o_underrun (o_underrun)
   );

   word_checksum ck0 (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_data  (ff_rd_data),
      .i_valid (ff_rd_valid), // only words that really left the fifo
      .o_sum   (o_sum),
      .o_count (o_count)
   );

   // all three blocks share the one clock and the synchronous reset
   // nothing else lives at this level

endmodule

/* verilog/word_checksum.sv */
`timescale 1ns/1ps

// consumer side of the buffer
// adds every delivered word into a 32 bit running sum
// and counts how many words were delivered
// validity is decided by the fifo, so no flags are looked at here

module word_checksum (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  stream_buffer_pkg::word_t  i_data,  // word from the fifo
   input  logic                      i_valid, // i_data is a real delivery
   output stream_buffer_pkg::word_t  o_sum,   // running sum mod 2^32
   output stream_buffer_pkg::count_t o_count  // delivered words, wraps
);

   stream_buffer_pkg::word_t  next_sum;
   stream_buffer_pkg::count_t next_count;

   // carry out of bit 31 is simply lost
   assign next_sum   = o_sum + i_data;
   assign next_count = o_count + stream_buffer_pkg::count_t'(1);

   // both outputs move together, one cycle after the valid pulse
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_sum   <= '0;
         o_count <= '0;
      end else if (i_valid) begin
         o_sum   <= next_sum;
         o_count <= next_count;
      end
   end

   // no hold or clear inputs
   // the only way back to zero is reset
   // o_sum and o_count are visible every cycle, there is no strobe with them

   // the sum is order independent, so it catches lost or duplicated words
   // but not words delivered out of order
   // the byte order inside a word does matter, since the lanes weigh
   // differently in the sum

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

`include "stream_buffer_defines.svh"

// synchronous word fifo with clocked memory
// occupancy counter decides empty and full, no pointer compare tricks
// overrun and underrun are sticky until reset
// read data is registered and marked by a one cycle valid

module sync_fifo (
   input  logic                     i_clk,
   input  logic                     i_rst,
   input  stream_buffer_pkg::word_t i_wr_data,  // word from the producer
   input  logic                     i_write,    // write strobe
   input  logic                     i_pop,      // read request strobe
   output stream_buffer_pkg::word_t o_rd_data,  // registered read word
   output logic                     o_rd_valid, // o_rd_data holds a delivered word
   output logic                     o_empty,
   output logic                     o_full,
   output logic                     o_overrun,  // a write was dropped
   output logic                     o_underrun  // a pop hit an empty fifo
);

   localparam stream_buffer_pkg::fifo_level_t DEPTH_LVL =
      stream_buffer_pkg::fifo_level_t'(`FIFO_DEPTH);

   stream_buffer_pkg::word_t      mem [0:`FIFO_DEPTH-1]; // storage, no reset
   stream_buffer_pkg::fifo_addr_t wr_ptr;
   stream_buffer_pkg::fifo_addr_t rd_ptr;
   stream_buffer_pkg::fifo_level_t level;      // words currently held
   stream_buffer_pkg::fifo_level_t next_level;

   logic rd_ok;  // honoured pop
   logic wr_ok;  // accepted write
   logic is_empty;
   logic is_full;

   assign is_empty = (level == '0);
   assign is_full  = (level == DEPTH_LVL);

   // a pop only counts when something is stored
   assign rd_ok = i_pop & ~is_empty;

   // full still accepts a write if a pop frees a slot in the same cycle
   assign wr_ok = i_write & (~is_full | rd_ok);

   // occupancy after this cycle
   always_comb begin
      case ({wr_ok, rd_ok})
         2'b10:   next_level = level + stream_buffer_pkg::fifo_level_t'(1);
         2'b01:   next_level = level - stream_buffer_pkg::fifo_level_t'(1);
         default: next_level = level; // idle, or write and read cancel
      endcase
   end

   // pointers, level and the status levels
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         level      <= '0;
         o_empty    <= 1'b1;
         o_full     <= 1'b0;
         o_rd_valid <= 1'b0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + stream_buffer_pkg::fifo_addr_t'(1); // natural wrap
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + stream_buffer_pkg::fifo_addr_t'(1);
         end
         level      <= next_level;
         o_empty    <= (next_level == '0);      // registered from next level
         o_full     <= (next_level == DEPTH_LVL);
         o_rd_valid <= rd_ok;
      end
   end

   // sticky error flags
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_overrun  <= 1'b0;
         o_underrun <= 1'b0;
      end else begin
         if (i_write & ~wr_ok) begin
            o_overrun <= 1'b1;  // word lost, source has no way to wait
         end
         if (i_pop & is_empty) begin
            o_underrun <= 1'b1; // nothing to hand out
         end
      end
   end

   // memory write port
   always_ff @(posedge i_clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= i_wr_data;
      end
   end

   // memory read port
   // when full with a write and read together both hit the same slot,
   // the read takes the old word since both are nonblocking
   always_ff @(posedge i_clk) begin
      if (rd_ok) begin
         o_rd_data <= mem[rd_ptr];
      end
   end

endmodule

/* verilog/byte_packer.sv */
`timescale 1ns/1ps

// gathers four byte strobes into one little-endian word
// first byte of a group lands in bits 7..0, fourth in bits 31..24
// the finished word goes out with a single cycle write pulse
// there is no back-pressure, a word is pushed whether or not the fifo can take it

module byte_packer (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  stream_buffer_pkg::byte_t  i_byte,     // incoming byte
   input  logic                      i_byte_stb, // one cycle per byte
   output stream_buffer_pkg::word_t  o_word,     // assembled word to the fifo
   output logic                      o_write     // pulses with o_word
);

   stream_buffer_pkg::lane_t lane;      // lane that the next byte fills
   stream_buffer_pkg::word_t asm_word;  // partial word under construction
   stream_buffer_pkg::word_t next_word; // asm_word with the current byte merged in
   logic                     last_lane; // this strobe completes the word

   assign last_lane = (lane == stream_buffer_pkg::lane_t'(3));

   // drop the incoming byte into its lane
   always_comb begin
      next_word = asm_word;
      next_word[{lane, 3'b000} +: 8] = i_byte; // lane*8 as a bit offset
   end

   // lane counter and write pulse
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         lane    <= '0;
         o_write <= 1'b0;
      end else begin
         o_write <= 1'b0; // default, only high for one cycle
         if (i_byte_stb) begin
            lane <= lane + stream_buffer_pkg::lane_t'(1); // wraps 3 -> 0 by itself
            if (last_lane) begin
               o_write <= 1'b1;
            end
         end
      end
   end

   // payload registers
   always_ff @(posedge i_clk) begin
      if (i_byte_stb) begin
         asm_word <= next_word; // lanes not yet written keep stale bytes
         if (last_lane) begin
            o_word <= next_word; // complete word, lines up with o_write
         end
      end
   end

   // note that stale bytes in asm_word never leak out
   // every lane is overwritten before the fourth strobe registers the word

   // one byte per cycle at most, so the packer can emit a word every
   // fourth cycle, well within what the fifo accepts per cycle

endmodule

/* verilog/stream_buffer_pkg.sv */
package stream_buffer_pkg;

   `include "stream_buffer_defines.svh"

   // one input byte as it arrives from the source
   typedef logic [7:0] byte_t;

   // one packed word, also used for the running checksum
   typedef logic [31:0] word_t;

   // byte position inside the word being filled, 0 is bits 7..0
   typedef logic [1:0] lane_t;

   // read or write pointer into the fifo memory
   typedef logic [`FIFO_ADDR_BITS-1:0] fifo_addr_t;

   // occupancy, one bit wider than a pointer
   // holds 0 up to FIFO_DEPTH inclusive
   typedef logic [`FIFO_ADDR_BITS:0] fifo_level_t;

   // number of words handed to the consumer
   typedef logic [`COUNT_BITS-1:0] count_t;

endpackage

/* verilog/stream_buffer_defines.svh */
`ifndef STREAM_BUFFER_DEFINES_SVH
`define STREAM_BUFFER_DEFINES_SVH

// sizing for the capture buffer

// log2 of the fifo depth
// 4 gives a 16 word buffer
`define FIFO_ADDR_BITS 4

// number of entries in the fifo memory
// also the occupancy value that means full
`define FIFO_DEPTH (1 << `FIFO_ADDR_BITS)

// width of the delivered word counter
// wraps silently when it runs over
`define COUNT_BITS 16

// the level counter needs one bit more than a pointer
// so that 0 and FIFO_DEPTH can both be held

`endif
